//--- blaster_macros.svh
`ifndef BLASTER_MACROS_SVH
`define BLASTER_MACROS_SVH

////////////////////////////////////////
// key codes, bit 4 set means pressed
////////////////////////////////////////
`define KEY_FIRE      5'h10
`define KEY_TONE_0    5'h11
`define KEY_TONE_7    5'h18
`define KEY_CHARGE    5'h1A
`define KEY_DUMP      5'h1B

// keypad scan, four row slots per frame
`define KEY_DIV_BITS  12
`define KEY_SAMPLE_PT 10'h3F0 // column sample point inside a row slot

// tone half-period reloads
`define TONE_0        16'h2CCA
`define TONE_1        16'h27E7
`define TONE_2        16'h238D
`define TONE_3        16'h218E
`define TONE_4        16'h1DE5
`define TONE_5        16'h1AA2
`define TONE_6        16'h17BA
`define TONE_7        16'h1665

////////////////////////////////////////
// pwm pulse train limits, in clk cycles
////////////////////////////////////////
`define PWM_MIN_ON    32
`define PWM_MAX_ON    768
`define PWM_MIN_OFF   144
`define PWM_PULSES    30
`define ILIM_HI       430 // adc counts, ends a pulse
`define ILIM_LO       390 // adc counts, allows next pulse

`define TRIG_DIV_BITS 16 // fire accepted when trigger counter wraps
`define AVG_LOG2      8  // 256 samples per window

`endif

//--- blaster_pkg.sv
package blaster_pkg;

	////////////////////////////////////////
	// shared design types
	////////////////////////////////////////

	// bit 4 pressed flag, low nibble the key
	typedef logic [4:0] key_code_t;

	// unsigned current sample from the adc
	typedef logic [11:0] adc_sample_t;

	// one of eight speaker tones
	typedef logic [2:0] tone_sel_t;

	// half-period reload for the tone counter
	typedef logic [15:0] tone_period_t;

	// pwm pulse train states
	typedef enum logic [1:0] {
		PULSE_IDLE = 2'd0, // waiting for an accepted fire
		PULSE_ON   = 2'd1, // output driven high
		PULSE_OFF  = 2'd2  // gap, waiting on time and current
	} pulse_state_t;

endpackage

//--- cmd_if.sv
interface cmd_if;
	import blaster_pkg::*;

	key_code_t key;      // latched key code
	logic      fire;
	logic      tone_on;
	tone_sel_t tone_sel;
	logic      charge;
	logic      dump;

	// decoded levels, all registered by the decoder
	modport decoder (output key, fire, tone_on, tone_sel, charge, dump);

	modport tone (input tone_on, tone_sel);

	modport pulse (input fire);

endinterface

//--- keypad_decoder.sv
`include "blaster_macros.svh"

module keypad_decoder (
	input  logic       clk,
	input  logic       reset,
	output logic [3:0] row_drive, // active low
	input  logic [2:0] col_sense, // active low
	input  logic [2:0] iset,
	cmd_if.decoder     cmd
);
	import blaster_pkg::*;

	logic [`KEY_DIV_BITS-1:0] div;
	logic [1:0]               scan_row;
	logic                     sample_pt;
	logic                     frame_end;
	logic                     hit;       // a key seen in this frame
	logic [1:0]               hit_row;
	logic [2:0]               hit_col;   // active high

	// row/column to key code, leftmost column wins
	function automatic key_code_t key_lookup(input logic [1:0] row, input logic [2:0] col);
		logic [1:0] idx;
		idx = col[2] ? 2'd0 : (col[1] ? 2'd1 : 2'd2);
		if (row == 2'd3) begin
			case (idx)
				2'd0:    return `KEY_CHARGE;
				2'd1:    return `KEY_FIRE;
				default: return `KEY_DUMP;
			endcase
		end
		return key_code_t'(`KEY_TONE_0 + 3 * row + idx);
	endfunction

	assign scan_row  = div[`KEY_DIV_BITS-1 -: 2];
	assign sample_pt = (div[`KEY_DIV_BITS-3:0] == `KEY_SAMPLE_PT);
	assign frame_end = (div == '1);

	////////////////////////////////////////
	// matrix scan
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			div       <= '0;
			row_drive <= '1;
			hit       <= 1'b0;
			cmd.key   <= '0;
		end else begin
			div       <= div + 1'b1;
			row_drive <= ~(4'b0001 << scan_row); // one row low per slot
			if (frame_end) begin
				// publish once per frame, clear on an empty frame
				cmd.key <= hit ? key_lookup(hit_row, hit_col) : key_code_t'(0);
				hit     <= 1'b0;
			end else if (sample_pt && col_sense != 3'b111) begin
				hit <= 1'b1;
			end
		end
	end

	// position of the press
	always_ff @(posedge clk) begin
		if (sample_pt && col_sense != 3'b111) begin
			hit_row <= scan_row;
			hit_col <= ~col_sense;
		end
	end

	////////////////////////////////////////
	// key to commands, one cycle behind key
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			cmd.fire     <= 1'b0;
			cmd.tone_on  <= 1'b0;
			cmd.tone_sel <= '0;
			cmd.charge   <= 1'b0;
			cmd.dump     <= 1'b0;
		end else begin
			cmd.fire     <= (cmd.key == `KEY_FIRE);
			cmd.tone_on  <= (cmd.key >= `KEY_TONE_0) && (cmd.key <= `KEY_TONE_7);
			cmd.tone_sel <= tone_sel_t'(cmd.key - `KEY_TONE_0);
			// iset switches are active low overrides
			cmd.charge   <= !iset[2] || (cmd.key == `KEY_CHARGE);
			cmd.dump     <= !iset[1] || (cmd.key == `KEY_DUMP);
		end
	end

endmodule

//--- tone_generator.sv
`include "blaster_macros.svh"

module tone_generator (
	input  logic clk,
	input  logic reset,
	cmd_if.tone  cmd,
	output logic speaker,
	output logic speaker_n
);
	import blaster_pkg::*;

	tone_period_t tone_cnt;
	logic         spk_en;
	logic         spk_toggle;

	function automatic tone_period_t tone_reload(input tone_sel_t sel);
		case (sel)
			3'd0:    return `TONE_0;
			3'd1:    return `TONE_1;
			3'd2:    return `TONE_2;
			3'd3:    return `TONE_3;
			3'd4:    return `TONE_4;
			3'd5:    return `TONE_5;
			3'd6:    return `TONE_6;
			default: return `TONE_7;
		endcase
	endfunction

	// each level holds for reload+1 cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			tone_cnt   <= '0;
			spk_en     <= 1'b0;
			spk_toggle <= 1'b0;
		end else if (tone_cnt == '0) begin
			spk_toggle <= !spk_toggle;
			spk_en     <= cmd.tone_on; // enable only changes at a reload
			tone_cnt   <= cmd.tone_on ? tone_reload(cmd.tone_sel) : tone_period_t'(0);
		end else begin
			tone_cnt <= tone_cnt - 1'b1;
		end
	end

	// differential drive, doubles the swing
	assign speaker   = spk_toggle & spk_en;
	assign speaker_n = !speaker;

endmodule

//--- pulse_generator.sv
`include "blaster_macros.svh"

module pulse_generator (
	input  logic                   clk,
	input  logic                   reset,
	cmd_if.pulse                   cmd,
	input  logic                   fire_button,
	input  logic                   ad_strobe,
	input  blaster_pkg::adc_sample_t ad_current,
	output logic                   pwm
);
	import blaster_pkg::*;

	localparam int TIME_W = $clog2(`PWM_MAX_ON + 1);
	localparam int CNT_W  = $clog2(`PWM_PULSES + 1);

	adc_sample_t               ad_hold;     // last strobed sample
	logic [`TRIG_DIV_BITS-1:0] trig_cnt;
	pulse_state_t              state;
	logic [TIME_W-1:0]         pulse_time;
	logic [CNT_W-1:0]          pulses_left;
	logic                      ramp_flag;   // short pulses while current ramps
	logic                      fire_req;
	logic                      over_hi;
	logic                      under_lo;

	always_ff @(posedge clk) begin
		if (reset) begin
			ad_hold  <= '0;
			trig_cnt <= '0;
		end else begin
			trig_cnt <= trig_cnt + 1'b1; // free running trigger gate
			if (ad_strobe) begin
				ad_hold <= ad_current;
			end
		end
	end

	assign fire_req = fire_button || cmd.fire;
	assign over_hi  = (ad_hold > `ILIM_HI);
	assign under_lo = (ad_hold < `ILIM_LO);

	////////////////////////////////////////
	// pulse train FSM
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= PULSE_IDLE;
			pulse_time  <= '0;
			pulses_left <= '0;
			ramp_flag   <= 1'b1;
		end else begin
			case (state)
				PULSE_IDLE: begin
					ramp_flag  <= 1'b1;
					pulse_time <= '0;
					if (fire_req && trig_cnt == '0) begin
						state       <= PULSE_ON;
						pulse_time  <= TIME_W'(1);
						pulses_left <= CNT_W'(`PWM_PULSES);
					end
				end
				PULSE_ON: begin
					if (pulse_time < `PWM_MIN_ON) begin
						pulse_time <= pulse_time + 1'b1; // min width always served
					end else if (ramp_flag || pulse_time >= `PWM_MAX_ON || over_hi) begin
						pulse_time  <= '0;
						pulses_left <= pulses_left - 1'b1;
						state       <= (pulses_left == CNT_W'(1)) ? PULSE_IDLE : PULSE_OFF;
					end else begin
						pulse_time <= pulse_time + 1'b1;
					end
				end
				PULSE_OFF: begin
					if (pulse_time < `PWM_MIN_OFF) begin
						pulse_time <= pulse_time + 1'b1;
					end else if (under_lo) begin
						state      <= PULSE_ON;
						pulse_time <= TIME_W'(1);
					end else begin
						ramp_flag <= 1'b0; // current reached target, go long
					end
				end
				default: state <= PULSE_IDLE;
			endcase
		end
	end

	assign pwm = (state == PULSE_ON);

endmodule

//--- current_averager.sv
`include "blaster_macros.svh"

module current_averager (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ad_strobe,
	input  blaster_pkg::adc_sample_t ad_current,
	output blaster_pkg::adc_sample_t avg_current
);
	import blaster_pkg::*;

	localparam int SMP_W = $bits(adc_sample_t);
	localparam int ACC_W = SMP_W + `AVG_LOG2; // no overflow over a full window

	logic [ACC_W-1:0]     acc;
	logic [`AVG_LOG2-1:0] win_cnt;

	////////////////////////////////////////
	// windowed mean
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			acc         <= '0;
			win_cnt     <= '0;
			avg_current <= '0;
		end else if (ad_strobe) begin
			win_cnt <= win_cnt + 1'b1;
			if (win_cnt == '0) begin
				// window start, publish the previous sum / 2^AVG_LOG2
				avg_current <= acc[ACC_W-1 -: SMP_W];
				acc         <= ACC_W'(ad_current);
			end else begin
				acc <= acc + ACC_W'(ad_current);
			end
		end
	end

endmodule

//--- blaster_top.sv
module blaster_top (
	input  logic                     clk,
	input  logic                     reset,
	// keypad matrix
	output logic [3:0]               row_drive,
	input  logic [2:0]               col_sense,
	// switches and button
	input  logic [2:0]               iset,
	input  logic                     fire_button,
	// current samples
	input  logic                     ad_strobe,
	input  blaster_pkg::adc_sample_t ad_current,
	// outputs
	output blaster_pkg::key_code_t   key,
	output logic                     speaker,
	output logic                     speaker_n,
	output logic                     charge,
	output logic                     dump,
	output logic                     pwm,
	output blaster_pkg::adc_sample_t avg_current
);

	cmd_if cmd ();

	////////////////////////////////////////
	// decode stage
	////////////////////////////////////////
	keypad_decoder u_decoder (
		.clk       (clk),
		.reset     (reset),
		.row_drive (row_drive),
		.col_sense (col_sense),
		.iset      (iset),
		.cmd       (cmd.decoder)
	);

	assign key    = cmd.key;
	assign charge = cmd.charge; // to the charger enable
	assign dump   = cmd.dump;

	// execute stage
	tone_generator u_tone (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd.tone),
		.speaker   (speaker),
		.speaker_n (speaker_n)
	);

	pulse_generator u_pulse (
		.clk         (clk),
		.reset       (reset),
		.cmd         (cmd.pulse),
		.fire_button (fire_button),
		.ad_strobe   (ad_strobe),
		.ad_current  (ad_current),
		.pwm         (pwm)
	);

	// result stage
	current_averager u_avg (
		.clk         (clk),
		.reset       (reset),
		.ad_strobe   (ad_strobe),
		.ad_current  (ad_current),
		.avg_current (avg_current)
	);

endmodule

//--- blaster_checker.sv
`include "blaster_macros.svh"

module blaster_checker (
	input logic                   clk,
	input logic                   reset,
	input logic                   speaker,
	input logic                   speaker_n,
	input logic                   pwm,
	input logic                   dump,
	input blaster_pkg::key_code_t key,
	input logic [2:0]             iset
);

	int unsigned pwm_run; // length of the current high run

	always_ff @(posedge clk) begin
		if (reset) begin
			pwm_run <= 0;
		end else begin
			pwm_run <= pwm ? pwm_run + 1 : 0;
		end
	end

	////////////////////////////////////////
	// output properties
	////////////////////////////////////////
	speaker_diff: assert property (@(posedge clk) disable iff (reset) speaker_n == !speaker)
		else $error("speaker_n is not the complement of speaker");

	pwm_max_on: assert property (@(posedge clk) pwm_run <= `PWM_MAX_ON)
		else $error("pwm high for more than the maximum on time");

	// dump lags key and iset by one register
	dump_source: assert property (@(posedge clk) disable iff (reset)
		dump |-> ($past(key) == `KEY_DUMP || !$past(iset[1])))
		else $error("dump high without dump key or iset override");

	pwm_reset: assert property (@(posedge clk) reset && $past(reset) |-> !pwm)
		else $error("pwm high during reset");

endmodule

bind blaster_top blaster_checker u_checker (
	.clk       (clk),
	.reset     (reset),
	.speaker   (speaker),
	.speaker_n (speaker_n),
	.pwm       (pwm),
	.dump      (dump),
	.key       (key),
	.iset      (iset)
);

//--- blaster_tb.sv
`include "blaster_macros.svh"

module blaster_tb;
	import blaster_pkg::*;

	logic        clk;
	logic        reset;
	logic [3:0]  row_drive;
	logic [2:0]  col_sense;
	logic [2:0]  iset;
	logic        fire_button;
	logic        ad_strobe;
	adc_sample_t ad_current;
	key_code_t   key;
	logic        speaker;
	logic        speaker_n;
	logic        charge;
	logic        dump;
	logic        pwm;
	adc_sample_t avg_current;

	// keypad model state
	logic        key_down;
	logic [1:0]  key_row;
	logic [1:0]  key_col;

	logic [63:0] step_op[$];
	int          step_a[$];
	int          step_b[$];
	int          step_c[$];
	int          step_d[$];
	int          samples[$]; // every strobed sample since reset
	int          watchdog_cycles = 0;

	blaster_top DUT (.*);

	always #4 clk = !clk;

	// pressed key pulls its column low while its row is driven
	always_comb begin
		for (int c = 0; c < 3; c++) begin
			col_sense[c] = !(key_down && !row_drive[key_row] && key_col == 2'(c));
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%0t: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopping on error");
	endtask

	function automatic logic probe(input int sel);
		return sel == 0 ? pwm : speaker;
	endfunction

	// cycles until the probed signal reaches lvl
	task automatic wait_level(input int sel, input logic lvl, input int limit, input string what);
		int n;
		n = 0;
		while (probe(sel) !== lvl) begin
			if (n >= limit) abort_run(what);
			n++;
			@(negedge clk);
		end
	endtask

	task automatic level_length(input int sel, input logic lvl, output int n);
		n = 0;
		while (probe(sel) === lvl && n < 100000) begin
			n++;
			@(negedge clk);
		end
	endtask

	task automatic strobe_sample(input int v);
		@(posedge clk);
		ad_strobe  <= 1'b1;
		ad_current <= 12'(v);
		samples.push_back(v);
		@(posedge clk);
		ad_strobe <= 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_key(input int exp, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (32'(key) != exp && n < limit) begin
			n++;
			@(negedge clk);
		end
		check("key", 32'(key), exp);
	endtask

	task automatic press(input int r, input int c, input int code);
		@(posedge clk);
		key_row  <= 2'(r);
		key_col  <= 2'(c);
		key_down <= 1'b1;
		wait_key(code, 2 * 4096 + 2);
	endtask

	task automatic release_key();
		@(posedge clk);
		key_down <= 1'b0;
		wait_key(0, 2 * 4096 + 2);
	endtask

	task automatic tone_levels(input int reload);
		int n;
		wait_level(1, 1'b0, 4 * reload, "speaker stuck high");
		wait_level(1, 1'b1, 4 * reload, "speaker never toggled");
		level_length(1, 1'b1, n);
		check("speaker high cycles", n, reload + 1);
		level_length(1, 1'b0, n);
		check("speaker low cycles", n, reload + 1);
	endtask

	// fire only matters while the FSM is idle
	task automatic start_train();
		@(posedge clk);
		fire_button <= 1'b1;
		wait_level(0, 1'b1, 70000, "pwm did not start after fire");
	endtask

	task automatic fire_train(input int pulses, input int width, input int gap);
		int n;
		start_train();
		for (int i = 0; i < pulses; i++) begin
			level_length(0, 1'b1, n);
			check("pwm pulse width", n, width);
			if (i < pulses - 1) begin
				level_length(0, 1'b0, n);
				check("pwm gap", n, gap);
			end
		end
		repeat (gap + 10) begin
			if (pwm) abort_run("pwm pulse after the last pulse of the train");
			@(negedge clk);
		end
		@(posedge clk);
		fire_button <= 1'b0;
		@(negedge clk);
	endtask

	task automatic stall_train(input int lo, input int over, input int max_w);
		int n;
		start_train();
		level_length(0, 1'b1, n);
		check("pwm first pulse width", n, `PWM_MIN_ON);
		repeat (1000) begin
			if (pwm) abort_run("pwm train did not stall on high current");
			@(negedge clk);
		end
		strobe_sample(lo);
		wait_level(0, 1'b1, 200, "pwm did not resume on low current");
		n = 0;
		while (pwm && n < 2000) begin
			n++;
			@(posedge clk);
			if (n == 1) begin
				ad_strobe   <= 1'b1; // raise current right after the rise
				ad_current  <= 12'(over);
				fire_button <= 1'b0;
				samples.push_back(over);
			end else begin
				ad_strobe <= 1'b0;
			end
			@(negedge clk);
		end
		check("pwm width under limit", 32'(n <= max_w), 1);
	endtask

	task automatic sample_burst(input int count);
		int v;
		int s;
		longint sum;
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			v = int'($urandom % 4096);
			ad_strobe  <= 1'b1;
			ad_current <= 12'(v);
			samples.push_back(v);
		end
		@(posedge clk);
		ad_strobe <= 1'b0;
		repeat (2) @(negedge clk);
		// last window start publishes the window before it
		s = ((samples.size() - 1) / 256) * 256;
		sum = 0;
		for (int i = s - 256; i < s; i++) sum += samples[i];
		check("avg_current", 32'(avg_current), 32'(sum >> `AVG_LOG2));
	endtask

	////////////////////////////////////////
	// stimulus file and run
	////////////////////////////////////////
	initial begin
		int fd;
		int r;
		int a, b, c, d, budget;
		logic [63:0] tok;
		logic [8*120-1:0] rest;
		clk         = 1'b0;
		reset       = 1'b1;
		iset        = 3'b111;
		fire_button = 1'b0;
		ad_strobe   = 1'b0;
		ad_current  = '0;
		key_down    = 1'b0;
		key_row     = '0;
		key_col     = '0;
		void'($urandom(32'h128a5569));
		fd = $fopen("blaster_stimulus.txt", "r");
		if (fd == 0) abort_run("cannot open blaster_stimulus.txt");
		while (!$feof(fd)) begin
			tok = '0;
			r = $fscanf(fd, "%s", tok);
			if (r != 1) break;
			if (tok == "#") begin
				r = $fgets(rest, fd); // comment line
			end else begin
				r = $fscanf(fd, "%h %h %h %h %d", a, b, c, d, budget);
				if (r != 5) abort_run("malformed line in blaster_stimulus.txt");
				step_op.push_back(tok);
				step_a.push_back(a);
				step_b.push_back(b);
				step_c.push_back(c);
				step_d.push_back(d);
				watchdog_cycles += budget;
			end
		end
		$fclose(fd);
		watchdog_cycles += 20000;

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(negedge clk);

		foreach (step_op[i]) begin
			case (step_op[i])
				"key": begin
					press(step_a[i], step_b[i], step_c[i]);
					release_key();
				end
				"press":   press(step_a[i], step_b[i], step_c[i]);
				"release": release_key();
				"cmds": begin
					@(posedge clk); // one register behind key
					@(negedge clk);
					check("charge", 32'(charge), step_a[i]);
					check("dump", 32'(dump), step_b[i]);
				end
				"iset": begin
					@(posedge clk);
					iset <= 3'(step_a[i]);
					repeat (3) @(negedge clk);
					check("charge", 32'(charge), step_b[i]);
					check("dump", 32'(dump), step_c[i]);
				end
				"tone": begin
					press(step_a[i], step_b[i], step_c[i]);
					tone_levels(step_d[i]);
				end
				"current": strobe_sample(step_a[i]);
				"fire":    fire_train(step_a[i], step_b[i], step_c[i]);
				"stall":   stall_train(step_a[i], step_b[i], step_c[i]);
				"avg":     sample_burst(step_a[i]);
				default:   abort_run("unknown operation in blaster_stimulus.txt");
			endcase
		end

		$display("sim passed");
		$finish;
	end

	// watchdog from the summed step budgets
	initial begin
		@(negedge reset);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the run took longer than the stimulus budget");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- blaster_stimulus.txt
# op a b c d budget   (a-d hex, budget in cycles, decimal)
# key: row col code; cmds/iset: charge dump; tone: row col code reload
key 0 2 11 0 16388
key 0 1 12 0 16388
key 0 0 13 0 16388
key 1 2 14 0 16388
key 1 1 15 0 16388
key 1 0 16 0 16388
key 2 2 17 0 16388
key 2 1 18 0 16388
key 2 0 19 0 16388
key 3 2 1a 0 16388
key 3 1 10 0 16388
key 3 0 1b 0 16388
press 3 2 1a 0 8194
cmds 1 0 0 0 4
release 0 0 0 0 8194
press 3 0 1b 0 8194
cmds 0 1 0 0 4
release 0 0 0 0 8194
iset 3 1 0 0 8
iset 5 0 1 0 8
iset 7 0 0 0 8
tone 0 2 11 2cca 60000
release 0 0 0 0 8194
tone 2 1 18 1665 40000
release 0 0 0 0 8194
current 64 0 0 0 4
fire 1e 20 91 0 80000
current 190 0 0 0 4
stall 100 1c0 22 0 80000
avg 300 0 0 0 2000

//--- build.f
+incdir+.
blaster_pkg.sv
cmd_if.sv
keypad_decoder.sv
tone_generator.sv
pulse_generator.sv
current_averager.sv
blaster_top.sv
blaster_checker.sv
blaster_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = blaster_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
